//--- design/osd_dem_uart_pkg.sv
// shared types and constants of the debug uart emulation
// flit and register bus structs, 16550 register map, event packet words
package osd_dem_uart_pkg;

   // data width of one debug interconnect flit
   localparam int DII_FLIT_W = 16;

   // one flit on the debug interconnect
   typedef struct packed {
      logic                  valid;
      logic                  last;
      logic [DII_FLIT_W-1:0] data;
   } dii_flit_t;

   // one register request from the host bus wrapper
   typedef struct packed {
      logic       req;
      logic       write;
      logic [2:0] addr;
      logic [7:0] wdata;
   } uart_bus_t;

   // 16550 register addresses
   // with dlab set, 0 and 1 select dll and dlm
   localparam logic [2:0] REG_RBR_THR = 3'd0;
   localparam logic [2:0] REG_IER     = 3'd1;
   localparam logic [2:0] REG_IIR     = 3'd2;
   localparam logic [2:0] REG_LCR     = 3'd3;
   localparam logic [2:0] REG_MCR     = 3'd4;
   localparam logic [2:0] REG_LSR     = 3'd5;
   localparam logic [2:0] REG_MSR     = 3'd6;
   localparam logic [2:0] REG_SCR     = 3'd7;

   // line status bits
   localparam int LSR_DR   = 0;
   localparam int LSR_THRE = 5;
   localparam int LSR_TEMT = 6;

   // divisor latch access bit in lcr
   localparam int LCR_DLAB = 7;

   // interrupt enable bits, receive data and transmit empty
   localparam int IER_RDA  = 0;
   localparam int IER_THRE = 1;

   // interrupt identification codes
   localparam logic [7:0] IIR_NONE = 8'h01;
   localparam logic [7:0] IIR_THRE = 8'h02;
   localparam logic [7:0] IIR_RDA  = 8'h04;

   // event packet header words
   localparam logic [DII_FLIT_W-1:0] DII_HOST_ID    = 16'h0000;
   localparam logic [DII_FLIT_W-1:0] DII_TYPE_EVENT = 16'h0100;

   // entries per character buffer
   localparam int UART_FIFO_DEPTH = 16;

endpackage

//--- design/dem_uart_fifo.sv
// synchronous circular buffer, payload type set by a type parameter
`timescale 1ns/1ns

module dem_uart_fifo
   import osd_dem_uart_pkg::*;
   #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = UART_FIFO_DEPTH
   ) (
   input  logic clk,
   input  logic rst_n_i,
   input  logic wr_en_i,
   input  T     wr_data_i,
   output logic full_o,
   input  logic rd_en_i,
   output T     rd_data_o,
   output logic empty_o
   );

   // entry storage
   T mem [DEPTH];

   logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
   logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
   logic [$clog2(DEPTH+1)-1:0] count_q;
   logic                       do_wr;
   logic                       do_rd;

   // push when full and pop when empty are dropped
   assign do_wr = wr_en_i & ~full_o;
   assign do_rd = rd_en_i & ~empty_o;

   assign full_o  = (int'(count_q) == DEPTH);
   assign empty_o = (count_q == '0);

   // head entry visible without a read cycle
   assign rd_data_o = mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         // pointers wrap at DEPTH, which need not be a power of two
         if (do_wr) begin
            wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
         end
         // simultaneous push and pop keep the count
         if (do_wr && !do_rd) begin
            count_q <= count_q + 1'b1;
         end else if (do_rd && !do_wr) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

//--- design/osd_dem_uart_16550.sv
// 16550 register file emulation with tx and rx character buffers
// and the registered interrupt request
`timescale 1ns/1ns

module osd_dem_uart_16550
   import osd_dem_uart_pkg::*;
   (
   input  logic       clk,
   input  logic       rst_n_i,
   input  uart_bus_t  bus_i,
   output logic       bus_ack_o,
   output logic [7:0] bus_rdata_o,
   output logic       out_valid_o,
   output logic [7:0] out_char_o,
   input  logic       out_ready_i,
   input  logic       in_valid_i,
   input  logic [7:0] in_char_i,
   output logic       in_ready_o,
   output logic       irq_o
   );

   // software visible registers
   logic [7:0] ier_q;
   logic [7:0] lcr_q;
   logic [7:0] mcr_q;
   logic [7:0] scr_q;
   logic [7:0] dll_q;
   logic [7:0] dlm_q;

   // request handshake
   logic       ack_q;
   logic       hold_q;
   logic       accept;

   logic       dlab;
   logic       thr_write;
   logic       rbr_read;

   // buffer status
   logic       tx_full;
   logic       tx_empty;
   logic       rx_full;
   logic       rx_empty;
   logic [7:0] rx_head;

   logic [7:0] lsr;
   logic [7:0] iir;
   logic [7:0] rdata;

   // one accept per request, then wait for req to drop
   assign accept = bus_i.req & ~ack_q & ~hold_q;

   assign dlab      = lcr_q[LCR_DLAB];
   assign thr_write = accept & bus_i.write & ~dlab & (bus_i.addr == REG_RBR_THR);
   assign rbr_read  = accept & ~bus_i.write & ~dlab & (bus_i.addr == REG_RBR_THR);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q  <= 1'b0;
         hold_q <= 1'b0;
      end else begin
         ack_q  <= accept;
         // set after the ack, cleared by a cycle without req
         hold_q <= bus_i.req & (hold_q | ack_q);
      end
   end

   assign bus_ack_o = ack_q;

   // register writes land on the ack edge
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ier_q <= 8'h00;
         lcr_q <= 8'h00;
         mcr_q <= 8'h00;
         scr_q <= 8'h00;
         dll_q <= 8'h00;
         dlm_q <= 8'h00;
      end else if (accept && bus_i.write) begin
         case (bus_i.addr)
            REG_RBR_THR: begin
               // thr itself goes to the tx buffer
               if (dlab) begin
                  dll_q <= bus_i.wdata;
               end
            end
            REG_IER: begin
               if (dlab) begin
                  dlm_q <= bus_i.wdata;
               end else begin
                  ier_q <= {4'h0, bus_i.wdata[3:0]};
               end
            end
            REG_LCR: lcr_q <= bus_i.wdata;
            // modem control only stored, no line behavior
            REG_MCR: mcr_q <= {3'b000, bus_i.wdata[4:0]};
            REG_SCR: scr_q <= bus_i.wdata;
            // fcr, lsr and msr writes have no effect
            default: ;
         endcase
      end
   end

   // line status derived from buffer state
   always_comb begin
      lsr           = 8'h00;
      lsr[LSR_DR]   = ~rx_empty;
      lsr[LSR_THRE] = ~tx_full;
      lsr[LSR_TEMT] = tx_empty;
   end

   // received data has priority over tx empty
   always_comb begin
      if (ier_q[IER_RDA] && !rx_empty) begin
         iir = IIR_RDA;
      end else if (ier_q[IER_THRE] && tx_empty) begin
         iir = IIR_THRE;
      end else begin
         iir = IIR_NONE;
      end
   end

   // read mux, dlab swaps in the divisor latches
   always_comb begin
      case (bus_i.addr)
         REG_RBR_THR: rdata = dlab ? dll_q : (rx_empty ? 8'h00 : rx_head);
         REG_IER:     rdata = dlab ? dlm_q : ier_q;
         REG_IIR:     rdata = iir;
         REG_LCR:     rdata = lcr_q;
         REG_MCR:     rdata = mcr_q;
         REG_LSR:     rdata = lsr;
         REG_MSR:     rdata = 8'h00;
         REG_SCR:     rdata = scr_q;
         default:     rdata = 8'h00;
      endcase
   end

   // sampled before the rbr pop on the same edge
   always_ff @(posedge clk) begin
      if (accept && !bus_i.write) begin
         bus_rdata_o <= rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         irq_o <= 1'b0;
      end else begin
         irq_o <= (ier_q[IER_RDA] & ~rx_empty) | (ier_q[IER_THRE] & tx_empty);
      end
   end

   // characters toward the packet emitter
   dem_uart_fifo #(
      .T     (logic [7:0]),
      .DEPTH (UART_FIFO_DEPTH)
   ) u_tx_fifo (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .wr_en_i   (thr_write),
      .wr_data_i (bus_i.wdata),
      .full_o    (tx_full),
      .rd_en_i   (out_valid_o & out_ready_i),
      .rd_data_o (out_char_o),
      .empty_o   (tx_empty)
   );

   assign out_valid_o = ~tx_empty;

   // characters from incoming event packets
   dem_uart_fifo #(
      .T     (logic [7:0]),
      .DEPTH (UART_FIFO_DEPTH)
   ) u_rx_fifo (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .wr_en_i   (in_valid_i & in_ready_o),
      .wr_data_i (in_char_i),
      .full_o    (rx_full),
      .rd_en_i   (rbr_read),
      .rd_data_o (rx_head),
      .empty_o   (rx_empty)
   );

   assign in_ready_o = ~rx_full;

endmodule

//--- design/osd_dem_uart.sv
// packet emulator: tx characters become event packets,
// incoming event packets deliver rx characters
`timescale 1ns/1ns

module osd_dem_uart
   import osd_dem_uart_pkg::*;
   (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic [15:0] id_i,
   input  logic        out_valid_i,
   input  logic [7:0]  out_char_i,
   output logic        out_ready_o,
   output logic        in_valid_o,
   output logic [7:0]  in_char_o,
   input  logic        in_ready_i,
   input  dii_flit_t   debug_in_i,
   output logic        debug_in_ready_o,
   output dii_flit_t   debug_out_o,
   input  logic        debug_out_ready_i
   );

   // emitter state
   logic [1:0] tx_word_q;
   dii_flit_t  tx_flit;
   logic       flit_push;
   logic       flit_full;
   logic       flit_empty;
   dii_flit_t  flit_head;

   // parser state
   logic [2:0] rx_pos_q;
   logic       rx_type_ok_q;
   logic [7:0] rx_char_q;
   logic       rx_accept;

   // one flit per cycle while a character waits and the buffer has room
   assign flit_push = out_valid_i & ~flit_full;

   // character leaves the tx buffer with its last flit
   assign out_ready_o = flit_push & (tx_word_q == 2'd3);

   // header words, then the payload flit
   always_comb begin
      tx_flit.valid = 1'b1;
      tx_flit.last  = 1'b0;
      case (tx_word_q)
         2'd0: tx_flit.data = DII_HOST_ID;
         2'd1: tx_flit.data = id_i;
         2'd2: tx_flit.data = DII_TYPE_EVENT;
         default: begin
            tx_flit.data = DII_FLIT_W'(out_char_i);
            tx_flit.last = 1'b1;
         end
      endcase
   end

   // word counter wraps after the payload flit
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         tx_word_q <= 2'd0;
      end else if (flit_push) begin
         tx_word_q <= tx_word_q + 2'd1;
      end
   end

   // two entries decouple the emitter from output stalls
   dem_uart_fifo #(
      .T     (dii_flit_t),
      .DEPTH (2)
   ) u_out_fifo (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .wr_en_i   (flit_push),
      .wr_data_i (tx_flit),
      .full_o    (flit_full),
      .rd_en_i   (~flit_empty & debug_out_ready_i),
      .rd_data_o (flit_head),
      .empty_o   (flit_empty)
   );

   // head stays put until accepted
   always_comb begin
      debug_out_o       = flit_head;
      debug_out_o.valid = ~flit_empty;
   end

   // back-pressure straight from the rx buffer
   assign debug_in_ready_o = in_ready_i;
   assign rx_accept        = debug_in_i.valid & in_ready_i;

   // position 0 dest, 1 src, 2 type, 3 payload, 4 saturates on extra words
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         rx_pos_q     <= 3'd0;
         rx_type_ok_q <= 1'b0;
      end else if (rx_accept) begin
         if (debug_in_i.last) begin
            rx_pos_q <= 3'd0;
         end else if (rx_pos_q != 3'd4) begin
            rx_pos_q <= rx_pos_q + 3'd1;
         end
         if (rx_pos_q == 3'd2) begin
            rx_type_ok_q <= (debug_in_i.data == DII_TYPE_EVENT);
         end
      end
   end

   // payload byte held while extra words pass by
   always_ff @(posedge clk) begin
      if (rx_accept && rx_pos_q == 3'd3) begin
         rx_char_q <= debug_in_i.data[7:0];
      end
   end

   // deliver on the last flit of an event packet, short packets dropped
   assign in_valid_o = debug_in_i.valid & debug_in_i.last & rx_type_ok_q &
                       (rx_pos_q >= 3'd3);
   assign in_char_o  = (rx_pos_q == 3'd3) ? debug_in_i.data[7:0] : rx_char_q;

endmodule

//--- design/osd_dem_uart_wb.sv
// wishbone top level: byte lane mapping onto the register bus,
// the 16550 emulator and the packet emulator
`timescale 1ns/1ns

module osd_dem_uart_wb
   import osd_dem_uart_pkg::*;
   (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic [15:0] id_i,
   output logic        irq_o,
   input  logic [3:0]  wb_adr_i,
   input  logic        wb_cyc_i,
   input  logic [31:0] wb_dat_i,
   input  logic [3:0]  wb_sel_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [2:0]  wb_cti_i,
   input  logic [1:0]  wb_bte_i,
   output logic        wb_ack_o,
   output logic        wb_rty_o,
   output logic        wb_err_o,
   output logic [31:0] wb_dat_o,
   input  dii_flit_t   debug_in_i,
   output logic        debug_in_ready_o,
   output dii_flit_t   debug_out_o,
   input  logic        debug_out_ready_i
   );

   uart_bus_t  bus;
   logic       bus_ack;
   logic [7:0] bus_rdata;
   logic [1:0] lane;

   // character streams between the emulators
   logic       out_valid;
   logic [7:0] out_char;
   logic       out_ready;
   logic       in_valid;
   logic [7:0] in_char;
   logic       in_ready;

   // lowest selected lane gives the low address bits, big endian style
   always_comb begin
      if (wb_sel_i[0]) begin
         lane = 2'd3;
      end else if (wb_sel_i[1]) begin
         lane = 2'd2;
      end else if (wb_sel_i[2]) begin
         lane = 2'd1;
      end else begin
         lane = 2'd0;
      end
   end

   // cti and bte ignored, every cycle handled as classic
   always_comb begin
      bus.req   = wb_cyc_i & wb_stb_i;
      bus.write = wb_we_i;
      bus.addr  = {wb_adr_i[2], lane};
      bus.wdata = wb_dat_i[7:0];
   end

   assign wb_ack_o = bus_ack;
   assign wb_err_o = 1'b0;
   assign wb_rty_o = 1'b0;
   // same byte on every lane
   assign wb_dat_o = {4{bus_rdata}};

   osd_dem_uart_16550 u_16550 (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .bus_i       (bus),
      .bus_ack_o   (bus_ack),
      .bus_rdata_o (bus_rdata),
      .out_valid_o (out_valid),
      .out_char_o  (out_char),
      .out_ready_i (out_ready),
      .in_valid_i  (in_valid),
      .in_char_i   (in_char),
      .in_ready_o  (in_ready),
      .irq_o       (irq_o)
   );

   osd_dem_uart u_uart_emul (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .id_i              (id_i),
      .out_valid_i       (out_valid),
      .out_char_i        (out_char),
      .out_ready_o       (out_ready),
      .in_valid_o        (in_valid),
      .in_char_o         (in_char),
      .in_ready_i        (in_ready),
      .debug_in_i        (debug_in_i),
      .debug_in_ready_o  (debug_in_ready_o),
      .debug_out_o       (debug_out_o),
      .debug_out_ready_i (debug_out_ready_i)
   );

endmodule

//--- tests/osd_dem_uart_sva.sv
// protocol assertions on the top level ports, bound into the top
`timescale 1ns/1ns

module osd_dem_uart_sva
   import osd_dem_uart_pkg::*;
   (
   input logic      clk,
   input logic      rst_n_i,
   input logic      wb_cyc_i,
   input logic      wb_stb_i,
   input logic      wb_ack_o,
   input logic      wb_err_o,
   input logic      wb_rty_o,
   input logic      irq_o,
   input dii_flit_t debug_out_o,
   input logic      debug_out_ready_i
   );

   // failed assertion count
   int unsigned fail_count = 0;

   // ack answers a request seen on the previous edge
   ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
   else begin
      fail_count++;
      $error("wb_ack_o without a request in the previous cycle");
   end

   // single cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_ack_o |=> !wb_ack_o)
   else begin
      fail_count++;
      $error("wb_ack_o held for more than one cycle");
   end

   // no error or retry responses
   no_err_rty: assert property (@(posedge clk) disable iff (!rst_n_i)
      !wb_err_o && !wb_rty_o)
   else begin
      fail_count++;
      $error("wb_err_o or wb_rty_o went high");
   end

   // stalled flit keeps its value
   out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      debug_out_o.valid && !debug_out_ready_i |=> $stable(debug_out_o))
   else begin
      fail_count++;
      $error("debug_out_o changed while stalled");
   end

   // outputs quiet while reset is applied
   reset_quiet: assert property (@(posedge clk)
      !rst_n_i |=> !irq_o && !debug_out_o.valid)
   else begin
      fail_count++;
      $error("irq_o or debug_out_o valid high during reset");
   end

endmodule

bind osd_dem_uart_wb osd_dem_uart_sva u_sva (
   .clk               (clk),
   .rst_n_i           (rst_n_i),
   .wb_cyc_i          (wb_cyc_i),
   .wb_stb_i          (wb_stb_i),
   .wb_ack_o          (wb_ack_o),
   .wb_err_o          (wb_err_o),
   .wb_rty_o          (wb_rty_o),
   .irq_o             (irq_o),
   .debug_out_o       (debug_out_o),
   .debug_out_ready_i (debug_out_ready_i)
);

//--- tests/tb_osd_dem_uart.sv
// testbench for the wishbone debug uart emulation
// bus and flit tasks, reference queues, ready throttle and watchdog
`timescale 1ns/1ns

module tb_osd_dem_uart
   import osd_dem_uart_pkg::*;
   ();

   // id of this module on the debug interconnect
   localparam logic [15:0] DEM_ID = 16'h0005;
   // bus, packet and polling transactions of all tests together
   localparam int NUM_TXN    = 160;
   localparam int TIMEOUT_NS = NUM_TXN * 200 * 40;

   logic        clk;
   logic        rst_n_i;
   logic [15:0] id_i;
   logic        irq_o;
   logic [3:0]  wb_adr_i;
   logic        wb_cyc_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [2:0]  wb_cti_i;
   logic [1:0]  wb_bte_i;
   logic        wb_ack_o;
   logic        wb_rty_o;
   logic        wb_err_o;
   logic [31:0] wb_dat_o;
   dii_flit_t   debug_in_i;
   logic        debug_in_ready_o;
   dii_flit_t   debug_out_o;
   logic        debug_out_ready_i;

   // reference queues, flits as {last, data}
   logic [16:0] exp_flits [$];
   logic [7:0]  exp_rx [$];
   logic [16:0] flit_exp;
   bit          stall_en;

   osd_dem_uart_wb u_dut (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .id_i              (id_i),
      .irq_o             (irq_o),
      .wb_adr_i          (wb_adr_i),
      .wb_cyc_i          (wb_cyc_i),
      .wb_dat_i          (wb_dat_i),
      .wb_sel_i          (wb_sel_i),
      .wb_stb_i          (wb_stb_i),
      .wb_we_i           (wb_we_i),
      .wb_cti_i          (wb_cti_i),
      .wb_bte_i          (wb_bte_i),
      .wb_ack_o          (wb_ack_o),
      .wb_rty_o          (wb_rty_o),
      .wb_err_o          (wb_err_o),
      .wb_dat_o          (wb_dat_o),
      .debug_in_i        (debug_in_i),
      .debug_in_ready_o  (debug_in_ready_o),
      .debug_out_o       (debug_out_o),
      .debug_out_ready_i (debug_out_ready_i)
   );

   // 40 ns period
   always #20 clk = ~clk;

   task automatic halt_with_fail();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic verify_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      assert (act === exp) else begin
         $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, exp, act);
         halt_with_fail();
      end
   endtask

   // line status with the tx side idle
   function automatic logic [7:0] expected_lsr(input logic rx_pending);
      return {1'b0, 1'b1, 1'b1, 4'b0000, rx_pending};
   endfunction

   // one classic cycle, starts 2 ns after a rising edge
   // and leaves the request low for one cycle before returning
   task automatic bus_cycle(input logic we, input logic [2:0] r, input logic [7:0] d,
                            output logic [31:0] q);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = {1'b0, r[2], 2'b00};
      // low address bits come from the selected byte lane
      case (r[1:0])
         2'd3:    wb_sel_i = 4'b0001;
         2'd2:    wb_sel_i = 4'b0010;
         2'd1:    wb_sel_i = 4'b0100;
         default: wb_sel_i = 4'b1000;
      endcase
      wb_dat_i = {4{d}};
      do begin
         @(posedge clk);
         #2;
      end while (wb_ack_o !== 1'b1);
      q = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      @(posedge clk);
      #2;
   endtask

   task automatic wb_write(input logic [2:0] r, input logic [7:0] d);
      logic [31:0] unused;
      bus_cycle(1'b1, r, d, unused);
   endtask

   task automatic wb_read(input logic [2:0] r, output logic [31:0] q);
      bus_cycle(1'b0, r, 8'h00, q);
   endtask

   // read byte must show on all four lanes
   task automatic read_and_compare(input logic [2:0] r, input string name,
                                   input logic [7:0] exp);
      logic [31:0] q;
      wb_read(r, q);
      verify_value(name, {4{exp}}, q);
   endtask

   // four flits toward this module, each held until ready
   task automatic send_packet(input logic [15:0] ptype, input logic [7:0] ch);
      logic [15:0] words [4];
      words[0] = DEM_ID;
      words[1] = DII_HOST_ID;
      words[2] = ptype;
      words[3] = {8'h00, ch};
      for (int i = 0; i < 4; i++) begin
         debug_in_i.valid = 1'b1;
         debug_in_i.last  = (i == 3);
         debug_in_i.data  = words[i];
         // ready only changes at edges, so the negedge value decides the transfer
         do @(negedge clk); while (debug_in_ready_o !== 1'b1);
         @(posedge clk);
         #2;
      end
      debug_in_i = '0;
   endtask

   // packet expected for one character written to thr
   task automatic queue_tx_packet(input logic [7:0] ch);
      exp_flits.push_back({1'b0, DII_HOST_ID});
      exp_flits.push_back({1'b0, DEM_ID});
      exp_flits.push_back({1'b0, DII_TYPE_EVENT});
      exp_flits.push_back({1'b1, 8'h00, ch});
   endtask

   task automatic wait_for_irq(input logic level);
      do begin
         @(posedge clk);
         #2;
      end while (irq_o !== level);
   endtask

   // random output stalls while enabled
   always @(posedge clk) begin
      #2;
      if (stall_en) begin
         debug_out_ready_i = ($urandom % 3) != 0;
      end else begin
         debug_out_ready_i = 1'b1;
      end
   end

   // flit transfers compared against the reference queue
   always @(negedge clk) begin
      if (rst_n_i && debug_out_o.valid && debug_out_ready_i) begin
         if (exp_flits.size() == 0) begin
            $display("unexpected flit on debug_out_o with data %h", debug_out_o.data);
            halt_with_fail();
         end else begin
            flit_exp = exp_flits.pop_front();
            assert ({debug_out_o.last, debug_out_o.data} === flit_exp) else begin
               $display("[ERROR] time %0t: debug_out_o expected %h, got %h", $time,
                        flit_exp, {debug_out_o.last, debug_out_o.data});
               halt_with_fail();
            end
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired before the tests completed");
      halt_with_fail();
   end

   initial begin
      logic [7:0]  ch;
      logic [31:0] lsr;
      void'($urandom(32'h81ef));
      clk               = 1'b0;
      rst_n_i           = 1'b0;
      id_i              = DEM_ID;
      wb_adr_i          = '0;
      wb_cyc_i          = 1'b0;
      wb_dat_i          = '0;
      wb_sel_i          = '0;
      wb_stb_i          = 1'b0;
      wb_we_i           = 1'b0;
      wb_cti_i          = '0;
      wb_bte_i          = '0;
      debug_in_i        = '0;
      debug_out_ready_i = 1'b1;
      stall_en          = 1'b0;
      repeat (10) @(posedge clk);
      #2;
      rst_n_i = 1'b1;
      @(posedge clk);
      #2;

      // reset values, iir idle code
      read_and_compare(REG_RBR_THR, "rbr", 8'h00);
      read_and_compare(REG_IER, "ier", 8'h00);
      read_and_compare(REG_IIR, "iir", IIR_NONE);
      read_and_compare(REG_LCR, "lcr", 8'h00);
      read_and_compare(REG_MCR, "mcr", 8'h00);
      read_and_compare(REG_LSR, "lsr", expected_lsr(1'b0));
      read_and_compare(REG_MSR, "msr", 8'h00);
      read_and_compare(REG_SCR, "scr", 8'h00);
      verify_value("debug_in_ready_o", 1'b1, debug_in_ready_o);
      ch = 8'($urandom);
      wb_write(REG_SCR, ch);
      read_and_compare(REG_SCR, "scr", ch);
      wb_write(REG_LCR, 8'h1b);
      read_and_compare(REG_LCR, "lcr", 8'h1b);
      wb_write(REG_MCR, 8'h0b);
      read_and_compare(REG_MCR, "mcr", 8'h0b);

      // divisor latches behind dlab, no character may move
      wb_write(REG_LCR, 8'h9b);
      wb_write(REG_RBR_THR, 8'h5a);
      wb_write(REG_IER, 8'h3c);
      read_and_compare(REG_RBR_THR, "dll", 8'h5a);
      read_and_compare(REG_IER, "dlm", 8'h3c);
      wb_write(REG_LCR, 8'h1b);
      read_and_compare(REG_LSR, "lsr", expected_lsr(1'b0));
      read_and_compare(REG_IER, "ier", 8'h00);
      read_and_compare(REG_RBR_THR, "rbr", 8'h00);

      // sixteen characters out under random stalls
      stall_en = 1'b1;
      for (int n = 0; n < 16; n++) begin
         do wb_read(REG_LSR, lsr); while (!lsr[LSR_THRE]);
         ch = 8'($urandom);
         queue_tx_packet(ch);
         wb_write(REG_RBR_THR, ch);
      end
      while (exp_flits.size() != 0) begin
         @(posedge clk);
         #2;
      end
      stall_en = 1'b0;
      read_and_compare(REG_LSR, "lsr", expected_lsr(1'b0));

      // receive path in order
      for (int n = 0; n < 3; n++) begin
         ch = 8'($urandom);
         exp_rx.push_back(ch);
         send_packet(DII_TYPE_EVENT, ch);
      end
      read_and_compare(REG_LSR, "lsr", expected_lsr(1'b1));
      while (exp_rx.size() != 0) begin
         read_and_compare(REG_RBR_THR, "rbr", exp_rx.pop_front());
      end
      read_and_compare(REG_LSR, "lsr", expected_lsr(1'b0));

      // other packet types are swallowed
      send_packet(16'h0200, 8'ha5);
      read_and_compare(REG_LSR, "lsr", expected_lsr(1'b0));

      // receive interrupt
      wb_write(REG_IER, 8'h01);
      read_and_compare(REG_IIR, "iir", IIR_NONE);
      verify_value("irq_o", 1'b0, irq_o);
      ch = 8'($urandom);
      send_packet(DII_TYPE_EVENT, ch);
      wait_for_irq(1'b1);
      read_and_compare(REG_IIR, "iir", IIR_RDA);
      read_and_compare(REG_RBR_THR, "rbr", ch);
      wait_for_irq(1'b0);
      read_and_compare(REG_IIR, "iir", IIR_NONE);
      // tx empty interrupt
      wb_write(REG_IER, 8'h02);
      wait_for_irq(1'b1);
      read_and_compare(REG_IIR, "iir", IIR_THRE);
      wb_write(REG_IER, 8'h00);
      wait_for_irq(1'b0);

      // fill the rx buffer, the 17th packet must stall
      for (int n = 0; n < 16; n++) begin
         ch = 8'($urandom);
         exp_rx.push_back(ch);
         send_packet(DII_TYPE_EVENT, ch);
      end
      ch = 8'($urandom);
      exp_rx.push_back(ch);
      fork
         send_packet(DII_TYPE_EVENT, ch);
      join_none
      repeat (4) begin
         @(posedge clk);
         #2;
      end
      verify_value("debug_in_ready_o", 1'b0, debug_in_ready_o);
      repeat (16) begin
         read_and_compare(REG_RBR_THR, "rbr", exp_rx.pop_front());
      end
      do wb_read(REG_LSR, lsr); while (!lsr[LSR_DR]);
      read_and_compare(REG_RBR_THR, "rbr", exp_rx.pop_front());
      read_and_compare(REG_LSR, "lsr", expected_lsr(1'b0));

      @(posedge clk);
      #2;
      if (u_dut.u_sva.fail_count != 0) begin
         $display("protocol assertions failed");
         halt_with_fail();
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

//--- flist.f
design/osd_dem_uart_pkg.sv
design/dem_uart_fifo.sv
design/osd_dem_uart_16550.sv
design/osd_dem_uart.sv
design/osd_dem_uart_wb.sv
tests/osd_dem_uart_sva.sv
tests/tb_osd_dem_uart.sv

//--- run.sh
#!/usr/bin/env bash
# build the uart emulation testbench with verilator and run it
# the run passes only when the output holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_osd_dem_uart -o tb_sim \
   && sim_out="$(./obj_dir/tb_sim 2>&1)"
printf '%s\n' "$sim_out" \
   && grep -qx "Simulation finished: PASS" <<< "$sim_out" \
   && echo "run passed" \
   || { echo "run failed"; exit 1; }
